/* common/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int DATA_W = 8;
    localparam int ADDR_W = 16;

    localparam logic [ADDR_W-1:0] RESET_IP = 16'h0000;

    typedef enum logic {
        FETCH = 1'b0,
        EXEC  = 1'b1
    } phase_e;

    // codes above ALU_PASSB pass A through.
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_ADC   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_PASSB = 4'd5
    } alu_op_e;

    typedef enum logic [1:0] {
        OPND_B    = 2'd0,
        OPND_PL   = 2'd1,
        OPND_PH   = 2'd2,
        OPND_ZERO = 2'd3
    } operand_sel_e;

    typedef enum logic [1:0] {
        BUS_ALU = 2'd0,
        BUS_MEM = 2'd1,
        BUS_A   = 2'd2
    } bus_src_e;

    // carry sits at bit 1.
    typedef struct packed {
        logic v;
        logic n;
        logic c;
        logic z;
    } flags_t;

    typedef struct packed {
        alu_op_e      alu_op;
        logic         invert;
        logic         carry;    // arithmetic carry in.
        operand_sel_e operand;
        bus_src_e     bus_src;
        logic         we_a;
        logic         we_b;
        logic         we_flags;
        logic         we_pl;
        logic         we_ph;
        logic         ip_inc;
        logic         addr_dp;
        logic         swap_p;
        logic         mem_rd;
        logic         mem_wr;
    } ctrl_t;

    typedef struct packed {
        logic [DATA_W-1:0] result;
        flags_t            flags;
    } alu_out_t;

endpackage

`default_nettype wire

/* control/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit
    import cpu_pkg::*;
(
    input  wire logic              n_clk,
    input  wire logic              n_rst,
    input  wire logic [DATA_W-1:0] d_in,
    input  wire flags_t            flags,
    output ctrl_t                  ctrl,
    output logic                   n_oe,
    output logic                   n_we
);

    logic [DATA_W-1:0] ir;
    phase_e            phase;

    // fields of an ALU instruction.
    alu_op_e      ir_op;
    operand_sel_e ir_opnd;
    logic         ir_inv;
    logic         op_valid;

    assign ir_op    = alu_op_e'(ir[6:3]);
    assign ir_inv   = ir[2];
    assign ir_opnd  = operand_sel_e'(ir[1:0]);
    assign op_valid = (ir[6:3] <= 4'(ALU_PASSB));

    always_ff @(posedge n_clk or negedge n_rst) begin
        if (!n_rst) begin
            ir    <= '0;
            phase <= FETCH;
        end else if (phase == FETCH) begin
            ir    <= d_in;
            phase <= EXEC;
        end else begin
            phase <= FETCH;
        end
    end

    always_comb begin
        ctrl         = '0;
        ctrl.alu_op  = ir_op;
        ctrl.invert  = ir_inv;
        ctrl.operand = ir_opnd;
        ctrl.bus_src = BUS_ALU;

        if (phase == FETCH) begin
            ctrl.mem_rd = 1'b1;
            ctrl.ip_inc = 1'b1;
        end else if (!ir[7]) begin
            // ADD takes carry from invert, so SUB is ADD with invert.
            ctrl.carry    = (ir_op == ALU_ADC) ? flags.c : ir_inv;
            ctrl.we_a     = 1'b1;
            ctrl.we_flags = op_valid;
        end else begin
            unique case (ir[6:4])
                3'd0: begin                 // LDI A.
                    ctrl.bus_src = BUS_MEM;
                    ctrl.we_a    = 1'b1;
                    ctrl.mem_rd  = 1'b1;
                    ctrl.ip_inc  = 1'b1;
                end
                3'd1: begin                 // LDI B.
                    ctrl.bus_src = BUS_MEM;
                    ctrl.we_b    = 1'b1;
                    ctrl.mem_rd  = 1'b1;
                    ctrl.ip_inc  = 1'b1;
                end
                3'd2: begin                 // LD A, [DP].
                    ctrl.bus_src = BUS_MEM;
                    ctrl.we_a    = 1'b1;
                    ctrl.mem_rd  = 1'b1;
                    ctrl.addr_dp = 1'b1;
                end
                3'd3: begin                 // ST A, [DP].
                    ctrl.mem_wr  = 1'b1;
                    ctrl.addr_dp = 1'b1;
                end
                3'd4: begin
                    ctrl.bus_src = BUS_A;
                    ctrl.we_pl   = 1'b1;
                end
                3'd5: begin
                    ctrl.bus_src = BUS_A;
                    ctrl.we_ph   = 1'b1;
                end
                3'd6: begin
                    ctrl.swap_p  = 1'b1;
                end
                3'd7: begin                 // MOV B, A.
                    ctrl.bus_src = BUS_A;
                    ctrl.we_b    = 1'b1;
                end
            endcase
        end
    end

    assign n_oe = ~ctrl.mem_rd;
    assign n_we = ~ctrl.mem_wr;

endmodule

`default_nettype wire

/* datapath/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu
    import cpu_pkg::*;
(
    input  wire logic [DATA_W-1:0] a_val,
    input  wire logic [DATA_W-1:0] b_val,
    input  wire logic [DATA_W-1:0] pl,
    input  wire logic [DATA_W-1:0] ph,
    input  wire logic              carry_in,
    input  wire ctrl_t             ctrl,
    output alu_out_t               alu_out
);

    logic [DATA_W-1:0] opnd;
    logic [DATA_W-1:0] opnd_x;
    logic [DATA_W:0]   sum;
    logic [DATA_W-1:0] res;
    logic              c_out;
    logic              v_out;

    always_comb begin
        unique case (ctrl.operand)
            OPND_B:  opnd = b_val;
            OPND_PL: opnd = pl;
            OPND_PH: opnd = ph;
            default: opnd = '0;
        endcase
    end

    assign opnd_x = ctrl.invert ? ~opnd : opnd;
    assign sum    = {1'b0, a_val} + {1'b0, opnd_x} + (DATA_W+1)'(ctrl.carry);

    always_comb begin
        // logic ops keep the old carry.
        c_out = carry_in;
        v_out = 1'b0;
        unique case (ctrl.alu_op)
            ALU_ADD, ALU_ADC: begin
                res   = sum[DATA_W-1:0];
                c_out = sum[DATA_W];
                v_out = (a_val[DATA_W-1] == opnd_x[DATA_W-1])
                        && (res[DATA_W-1] != a_val[DATA_W-1]);
            end
            ALU_AND:   res = a_val & opnd_x;
            ALU_OR:    res = a_val | opnd_x;
            ALU_XOR:   res = a_val ^ opnd_x;
            ALU_PASSB: res = opnd_x;
            default:   res = a_val;
        endcase
    end

    always_comb begin
        alu_out.result  = res;
        alu_out.flags.z = (res == '0);
        alu_out.flags.c = c_out;
        alu_out.flags.n = res[DATA_W-1];
        alu_out.flags.v = v_out;
    end

endmodule

`default_nettype wire

/* datapath/pointer_pair.sv */
`timescale 1ns/1ps
`default_nettype none

module pointer_pair
    import cpu_pkg::*;
(
    input  wire logic              n_clk,
    input  wire logic              n_rst,
    input  wire ctrl_t             ctrl,
    input  wire logic [DATA_W-1:0] wdata,
    output logic [ADDR_W-1:0]      a,
    output logic [DATA_W-1:0]      pl,
    output logic [DATA_W-1:0]      ph
);

    logic [ADDR_W-1:0] ptr0;
    logic [ADDR_W-1:0] ptr1;
    logic              sel;    // which pointer is IP.

    logic [ADDR_W-1:0] ip;
    logic [ADDR_W-1:0] dp;
    logic [ADDR_W-1:0] ip_next;
    logic [ADDR_W-1:0] dp_next;

    assign ip = sel ? ptr1 : ptr0;
    assign dp = sel ? ptr0 : ptr1;

    always_comb begin
        ip_next = ip + ADDR_W'(ctrl.ip_inc);
        dp_next = dp;
        if (ctrl.we_pl) begin
            dp_next[DATA_W-1:0] = wdata;
        end
        if (ctrl.we_ph) begin
            dp_next[ADDR_W-1:DATA_W] = wdata;
        end
    end

    always_ff @(posedge n_clk or negedge n_rst) begin
        if (!n_rst) begin
            ptr0 <= RESET_IP;
            ptr1 <= RESET_IP;
            sel  <= 1'b0;
        end else begin
            ptr0 <= sel ? dp_next : ip_next;
            ptr1 <= sel ? ip_next : dp_next;
            if (ctrl.swap_p) begin
                sel <= ~sel;   // old DP becomes IP.
            end
        end
    end

    assign a  = ctrl.addr_dp ? dp : ip;
    assign pl = dp[DATA_W-1:0];
    assign ph = dp[ADDR_W-1:DATA_W];

endmodule

`default_nettype wire

/* datapath/data_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module data_regs
    import cpu_pkg::*;
(
    input  wire logic              n_clk,
    input  wire logic              n_rst,
    input  wire ctrl_t             ctrl,
    input  wire logic [DATA_W-1:0] d_in,
    input  wire alu_out_t          alu_out,
    output logic [DATA_W-1:0]      a_val,
    output logic [DATA_W-1:0]      b_val,
    output flags_t                 flags,
    output logic [DATA_W-1:0]      bus
);

    always_comb begin
        unique case (ctrl.bus_src)
            BUS_ALU: bus = alu_out.result;
            BUS_MEM: bus = d_in;
            BUS_A:   bus = a_val;
            default: bus = '0;
        endcase
    end

    always_ff @(posedge n_clk or negedge n_rst) begin
        if (!n_rst) begin
            a_val <= '0;
            b_val <= '0;
            flags <= '0;
        end else begin
            if (ctrl.we_a) begin
                a_val <= bus;
            end
            if (ctrl.we_b) begin
                b_val <= bus;
            end
            // flags come straight from the ALU.
            if (ctrl.we_flags) begin
                flags <= alu_out.flags;
            end
        end
    end

endmodule

`default_nettype wire

/* source/cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu
    import cpu_pkg::*;
(
    input  wire logic              n_clk,
    input  wire logic              n_rst,
    output logic [ADDR_W-1:0]      a,
    input  wire logic [DATA_W-1:0] d_in,
    output logic [DATA_W-1:0]      d_out,
    output logic                   n_oe,
    output logic                   n_we
);

    ctrl_t             ctrl;
    alu_out_t          alu_out;
    flags_t            flags;
    logic [DATA_W-1:0] a_val;
    logic [DATA_W-1:0] b_val;
    logic [DATA_W-1:0] pl;
    logic [DATA_W-1:0] ph;
    logic [DATA_W-1:0] bus;

    control_unit u_control (
        .n_clk (n_clk),
        .n_rst (n_rst),
        .d_in  (d_in),
        .flags (flags),
        .ctrl  (ctrl),
        .n_oe  (n_oe),
        .n_we  (n_we)
    );

    alu u_alu (
        .a_val    (a_val),
        .b_val    (b_val),
        .pl       (pl),
        .ph       (ph),
        .carry_in (flags.c),
        .ctrl     (ctrl),
        .alu_out  (alu_out)
    );

    pointer_pair u_pointers (
        .n_clk (n_clk),
        .n_rst (n_rst),
        .ctrl  (ctrl),
        .wdata (bus),
        .a     (a),
        .pl    (pl),
        .ph    (ph)
    );

    data_regs u_regs (
        .n_clk   (n_clk),
        .n_rst   (n_rst),
        .ctrl    (ctrl),
        .d_in    (d_in),
        .alu_out (alu_out),
        .a_val   (a_val),
        .b_val   (b_val),
        .flags   (flags),
        .bus     (bus)
    );

    assign d_out = a_val;   // valid while n_we is low.

endmodule

`default_nettype wire

/* testbench/tb_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_memory
    import cpu_pkg::*;
(
    input  wire logic              n_clk,
    input  wire logic [ADDR_W-1:0] a,
    input  wire logic [DATA_W-1:0] wdata,
    input  wire logic              n_oe,
    input  wire logic              n_we,
    output logic [DATA_W-1:0]      rdata
);

    logic [DATA_W-1:0] mem [0:(1<<ADDR_W)-1];

    assign rdata = n_oe ? 8'hff : mem[a];   // bus idles high.

    always @(posedge n_clk) begin
        if (!n_we) begin
            mem[a] <= wdata;
        end
    end

    // reserved opcodes everywhere, so stray fetches do nothing.
    task automatic fill();
        int i;
        logic [ADDR_W-1:0] addr;
        for (i = 0; i < (1 << ADDR_W); i++) begin
            addr   = ADDR_W'(i);
            mem[i] = 8'h40 | ((addr[15:8] ^ addr[7:0]) & 8'h3f);
        end
    endtask

    task automatic preload(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        mem[addr] = data;
    endtask

    task automatic peek(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        data = mem[addr];
    endtask

endmodule

`default_nettype wire

/* testbench/tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu
    import cpu_pkg::*;
();

    localparam int RESET_LEN    = 10;
    localparam int TRACE_LEN    = 32;
    localparam int TOTAL_INSTRS = 8 + 6 + 28 + 63 + 11 + 12;   // all six tests.
    localparam int CYCLE_LIMIT  = 6 * (RESET_LEN + 2) + 2 * TOTAL_INSTRS + 64;

    localparam logic [7:0] OP_LDI_A  = 8'h80;
    localparam logic [7:0] OP_LDI_B  = 8'h90;
    localparam logic [7:0] OP_LD_A   = 8'ha0;
    localparam logic [7:0] OP_ST_A   = 8'hb0;
    localparam logic [7:0] OP_DPL    = 8'hc0;
    localparam logic [7:0] OP_DPH    = 8'hd0;
    localparam logic [7:0] OP_SWAP   = 8'he0;
    localparam logic [7:0] OP_MOV_BA = 8'hf0;

    localparam logic [15:0] STORE_ADDR  = 16'h3c5a;
    localparam logic [15:0] ARITH_BASE  = 16'h4000;
    localparam logic [15:0] LOGIC_BASE  = 16'h5010;
    localparam logic [15:0] JUMP_TARGET = 16'h0080;
    localparam logic [15:0] JUMP_STORE  = 16'h7a3c;
    localparam logic [15:0] LOAD_SRC    = 16'h6123;
    localparam logic [15:0] LOAD_DST    = 16'h2e81;

    logic              n_clk;
    logic              n_rst;
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] d_in;
    logic [DATA_W-1:0] d_out;
    logic              n_oe;
    logic              n_we;

    integer            seed;
    int                errors;
    int                checks;
    int                cycle_count;
    int                instr_count;
    logic [ADDR_W-1:0] fill_ptr;
    logic [ADDR_W-1:0] trace_a [TRACE_LEN];
    logic              trace_oe [TRACE_LEN];
    logic              trace_we [TRACE_LEN];

    cpu uut (
        .n_clk (n_clk),
        .n_rst (n_rst),
        .a     (a),
        .d_in  (d_in),
        .d_out (d_out),
        .n_oe  (n_oe),
        .n_we  (n_we)
    );

    tb_memory mem_model (
        .n_clk (n_clk),
        .a     (a),
        .wdata (d_out),
        .n_oe  (n_oe),
        .n_we  (n_we),
        .rdata (d_in)
    );

    initial begin
        n_clk = 1'b0;
        forever #10 n_clk = ~n_clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge n_clk);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Errors found");
        $finish;
    end

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_mem(input logic [15:0] addr, input logic [7:0] exp);
        logic [7:0] data;
        mem_model.peek(addr, data);
        check_value($sformatf("mem[%h]", addr), {8'h00, data}, {8'h00, exp});
    endtask

    task automatic random_byte(output logic [7:0] b);
        logic [31:0] r;
        r = $random(seed);
        b = r[7:0];
    endtask

    function automatic logic [7:0] alu_instr(alu_op_e op, logic inv, operand_sel_e opnd);
        return {1'b0, op, inv, opnd};
    endfunction

    function automatic int we_low_count(int n_cycles);
        int k;
        int lows;
        lows = 0;
        for (k = 0; k < n_cycles && k < TRACE_LEN; k++) begin
            if (!trace_we[k]) begin
                lows++;
            end
        end
        return lows;
    endfunction

    // cpu held in reset while memory is rewritten.
    task automatic begin_program();
        @(posedge n_clk);
        n_rst <= 1'b0;
        @(negedge n_clk);
        mem_model.fill();
        fill_ptr    = RESET_IP;
        instr_count = 0;
    endtask

    task automatic put_byte(input logic [7:0] b);
        mem_model.preload(fill_ptr, b);
        fill_ptr++;
    endtask

    task automatic place_instr(input logic [7:0] b);
        put_byte(b);
        instr_count++;
    endtask

    task automatic load_imm(input logic [7:0] op, input logic [7:0] v);
        place_instr(op);
        put_byte(v);
    endtask

    task automatic point_dp(input logic [15:0] addr);
        load_imm(OP_LDI_A, addr[7:0]);
        place_instr(OP_DPL);
        load_imm(OP_LDI_A, addr[15:8]);
        place_instr(OP_DPH);
    endtask

    // dp high byte must already be set.
    task automatic alu_into_slot(input logic [7:0] slot, input logic [7:0] x,
                                 input logic [7:0] op);
        load_imm(OP_LDI_A, slot);
        place_instr(OP_DPL);
        load_imm(OP_LDI_A, x);
        place_instr(op);
        place_instr(OP_ST_A);
    endtask

    task automatic carry_into_slot(input logic [7:0] slot);
        load_imm(OP_LDI_A, slot);
        place_instr(OP_DPL);
        place_instr(alu_instr(ALU_PASSB, 1'b0, OPND_ZERO));   // a = 0, c kept.
        place_instr(alu_instr(ALU_ADC, 1'b0, OPND_ZERO));
        place_instr(OP_ST_A);
    endtask

    task automatic run_program(input int n_instr);
        int i;
        check_value("n_we in reset", n_we, 1'b1);
        for (i = 1; i < RESET_LEN; i++) begin
            @(posedge n_clk);
            @(negedge n_clk);
            check_value("n_we in reset", n_we, 1'b1);
        end
        @(posedge n_clk);
        n_rst <= 1'b1;
        for (i = 0; i < 2 * n_instr; i++) begin
            @(negedge n_clk);
            if (i < TRACE_LEN) begin
                trace_a[i]  = a;
                trace_oe[i] = n_oe;
                trace_we[i] = n_we;
            end
            @(posedge n_clk);
        end
        @(negedge n_clk);
    endtask

    task automatic reset_and_fetch();
        int k;
        begin_program();
        run_program(8);
        check_value("a after reset", trace_a[0], RESET_IP);
        for (k = 0; k < 8; k++) begin
            check_value("fetch address", trace_a[2*k], RESET_IP + 16'(k));
            check_value("n_oe in fetch", trace_oe[2*k], 1'b0);
        end
        check_value("n_we low cycles", we_low_count(16), 0);
    endtask

    task automatic load_and_store();
        logic [7:0] v;
        begin_program();
        random_byte(v);
        point_dp(STORE_ADDR);
        load_imm(OP_LDI_A, v);
        place_instr(OP_ST_A);
        run_program(instr_count);
        check_mem(STORE_ADDR, v);
        check_value("n_we low cycles", we_low_count(2 * instr_count), 1);
        check_value("n_we in store", trace_we[11], 1'b0);
        check_value("store address", trace_a[11], STORE_ADDR);
    endtask

    task automatic arithmetic_flags();
        logic [7:0] ra;
        logic [7:0] rb;
        logic [8:0] s_add;
        logic [8:0] s_sub;
        logic [8:0] s_adc;
        begin_program();
        random_byte(ra);
        random_byte(rb);
        load_imm(OP_LDI_A, ARITH_BASE[15:8]);
        place_instr(OP_DPH);
        load_imm(OP_LDI_B, rb);
        alu_into_slot(8'h00, ra, alu_instr(ALU_ADD, 1'b0, OPND_B));
        carry_into_slot(8'h01);
        alu_into_slot(8'h02, ra, alu_instr(ALU_ADD, 1'b1, OPND_B));
        alu_into_slot(8'h03, ra, alu_instr(ALU_ADC, 1'b0, OPND_B));   // uses sub carry.
        carry_into_slot(8'h04);
        run_program(instr_count);
        s_add = {1'b0, ra} + {1'b0, rb};
        s_sub = {1'b0, ra} + {1'b0, ~rb} + 9'd1;
        s_adc = {1'b0, ra} + {1'b0, rb} + {8'd0, s_sub[8]};
        check_mem(ARITH_BASE, s_add[7:0]);
        check_mem(ARITH_BASE + 16'd1, {7'd0, s_add[8]});
        check_mem(ARITH_BASE + 16'd2, s_sub[7:0]);
        check_mem(ARITH_BASE + 16'd3, s_adc[7:0]);
        check_mem(ARITH_BASE + 16'd4, {7'd0, s_adc[8]});
    endtask

    task automatic logic_operands();
        logic [7:0] ra;
        logic [7:0] rb;
        logic [7:0] opnd;
        logic [7:0] x;
        logic [7:0] expect_q [12];
        alu_op_e    op;
        int         i;
        begin_program();
        random_byte(ra);
        random_byte(rb);
        load_imm(OP_LDI_A, LOGIC_BASE[15:8]);
        place_instr(OP_DPH);
        load_imm(OP_LDI_B, rb);
        for (i = 0; i < 12; i++) begin
            op = (i < 4) ? ALU_AND : (i < 8) ? ALU_OR : ALU_XOR;
            case (i % 4)
                0:       opnd = rb;
                1:       opnd = LOGIC_BASE[7:0] + 8'(i);   // pl is the slot itself.
                2:       opnd = LOGIC_BASE[15:8];
                default: opnd = 8'h00;
            endcase
            x = (op == ALU_XOR) ? ~opnd : opnd;   // xor cases run inverted.
            case (op)
                ALU_AND: expect_q[i] = ra & x;
                ALU_OR:  expect_q[i] = ra | x;
                default: expect_q[i] = ra ^ x;
            endcase
            alu_into_slot(LOGIC_BASE[7:0] + 8'(i), ra,
                          alu_instr(op, op == ALU_XOR, operand_sel_e'(i % 4)));
        end
        run_program(instr_count);
        for (i = 0; i < 12; i++) begin
            check_mem(LOGIC_BASE + 16'(i), expect_q[i]);
        end
    endtask

    task automatic swap_jump();
        logic [7:0] v;
        begin_program();
        random_byte(v);
        point_dp(JUMP_TARGET);
        place_instr(OP_SWAP);
        fill_ptr = JUMP_TARGET;
        point_dp(JUMP_STORE);
        load_imm(OP_LDI_A, v);
        place_instr(OP_ST_A);
        run_program(instr_count);
        check_value("fetch after swap", trace_a[10], JUMP_TARGET);
        check_value("n_oe after swap", trace_oe[10], 1'b0);
        check_mem(JUMP_STORE, v);
    endtask

    task automatic load_via_dp();
        logic [7:0] v;
        begin_program();
        random_byte(v);
        mem_model.preload(LOAD_SRC, v);
        point_dp(LOAD_SRC);
        place_instr(OP_LD_A);
        place_instr(OP_MOV_BA);
        point_dp(LOAD_DST);
        place_instr(alu_instr(ALU_PASSB, 1'b0, OPND_B));
        place_instr(OP_ST_A);
        run_program(instr_count);
        check_value("load address", trace_a[9], LOAD_SRC);
        check_value("n_oe in load", trace_oe[9], 1'b0);
        check_mem(LOAD_DST, v);
    endtask

    initial begin
        n_rst  <= 1'b0;
        seed   = 32'hae3e3a93;
        errors = 0;
        checks = 0;
        reset_and_fetch();
        load_and_store();
        arithmetic_flags();
        logic_operands();
        swap_jump();
        load_via_dp();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cpu.f */
common/cpu_pkg.sv
control/control_unit.sv
datapath/alu.sv
datapath/pointer_pair.sv
datapath/data_regs.sv
source/cpu.sv
testbench/tb_memory.sv
testbench/tb_cpu.sv

/* Bender.yml */
package:
  name: cpu

sources:
  - common/cpu_pkg.sv
  - control/control_unit.sv
  - datapath/alu.sv
  - datapath/pointer_pair.sv
  - datapath/data_regs.sv
  - source/cpu.sv
  - target: test
    files:
      - testbench/tb_memory.sv
      - testbench/tb_cpu.sv
